/* hw/soc_pkg.sv */
// Bus types, address map, region sizes and game-pad timing shared by the SoC bus
package soc_pkg;

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;
	typedef logic [3:0] strb_t;
	typedef logic [1:0] resp_t;
	typedef logic [9:0] ram_index_t;
	// One bit per button, set when pressed
	typedef logic [7:0] buttons_t;

	localparam resp_t RESP_OKAY = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	typedef enum logic [1:0] {
		TGT_RAM,
		TGT_COUNTER,
		TGT_PAD,
		TGT_NONE
	} target_t;

	typedef enum logic [1:0] {
		PAD_LATCH,
		PAD_SHIFT,
		PAD_IDLE
	} pad_state_t;

	// Address map
	localparam addr_t RAM_BASE = 32'h0201_0000;
	localparam int RAM_ADDR_BITS = 12;
	localparam addr_t COUNTER_BASE = 32'h0200_0300;
	localparam addr_t PAD_BASE = 32'h0200_0200;
	localparam int REG_ADDR_BITS = 2;
	localparam int RAM_WORDS = 1024;

	// Pad scan timing, one frame is PAD_FRAME_TICKS half periods
	localparam int PAD_TICK_CYCLES = 256;
	localparam int PAD_BITS = 8;
	localparam int PAD_FRAME_TICKS = 16;

endpackage

/* hw/axil_decoder.sv */
// AXI-Lite subordinate with address decode, target strobes and response registers
`timescale 1ns/1ps

module axil_decoder (
	input logic clk_50mhz,
	input logic resetn,

	input soc_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input soc_pkg::data_t wdata,
	input soc_pkg::strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output soc_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,

	input soc_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output soc_pkg::data_t rdata,
	output soc_pkg::resp_t rresp,
	output logic rvalid,
	input logic rready,

	output logic ram_wr_en,
	output soc_pkg::ram_index_t ram_wr_index,
	output soc_pkg::data_t ram_wdata,
	output soc_pkg::strb_t ram_wstrb,
	output logic ram_rd_en,
	output soc_pkg::ram_index_t ram_rd_index,
	input soc_pkg::data_t ram_rdata,

	output logic counter_rd_en,
	output logic pad_rd_en,
	input soc_pkg::data_t count_value,
	input soc_pkg::data_t pad_value
);

	// Region hit when the bits above the region offset match its base
	function automatic soc_pkg::target_t decode_addr(input soc_pkg::addr_t addr);
		if ((addr >> soc_pkg::RAM_ADDR_BITS) == (soc_pkg::RAM_BASE >> soc_pkg::RAM_ADDR_BITS))
			return soc_pkg::TGT_RAM;
		if ((addr >> soc_pkg::REG_ADDR_BITS) ==
			(soc_pkg::COUNTER_BASE >> soc_pkg::REG_ADDR_BITS))
			return soc_pkg::TGT_COUNTER;
		if ((addr >> soc_pkg::REG_ADDR_BITS) == (soc_pkg::PAD_BASE >> soc_pkg::REG_ADDR_BITS))
			return soc_pkg::TGT_PAD;
		return soc_pkg::TGT_NONE;
	endfunction

	soc_pkg::target_t wr_tgt;
	soc_pkg::target_t rd_tgt;
	logic wr_fire;
	logic wr_pend;
	logic ar_fire;
	logic rd_busy;
	logic rd_strobe;
	logic rd_capture;

	// Address and data accepted together, only with no response pending
	assign wr_tgt = decode_addr(awaddr);
	assign wr_fire = awvalid && wvalid && !wr_pend && !bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;

	// Memory is written on the handshake edge itself
	assign ram_wr_en = wr_fire && (wr_tgt == soc_pkg::TGT_RAM);
	assign ram_wr_index = awaddr[soc_pkg::RAM_ADDR_BITS-1:2];
	assign ram_wdata = wdata;
	assign ram_wstrb = wstrb;

	assign arready = !rd_busy;
	assign ar_fire = arvalid && arready;

	assign ram_rd_en = rd_strobe && (rd_tgt == soc_pkg::TGT_RAM);
	assign counter_rd_en = rd_strobe && (rd_tgt == soc_pkg::TGT_COUNTER);
	assign pad_rd_en = rd_strobe && (rd_tgt == soc_pkg::TGT_PAD);

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			wr_pend <= 1'b0;
			bvalid <= 1'b0;
			rd_busy <= 1'b0;
			rd_strobe <= 1'b0;
			rd_capture <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			// Write response goes out the cycle after the handshake
			wr_pend <= wr_fire;
			if (wr_pend)
				bvalid <= 1'b1;
			else if (bready)
				bvalid <= 1'b0;

			// Strobe the target, then register its answer a cycle later
			rd_strobe <= ar_fire;
			rd_capture <= rd_strobe;

			if (ar_fire)
				rd_busy <= 1'b1;
			else if (rvalid && rready)
				rd_busy <= 1'b0;

			if (rd_capture)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (wr_fire) begin
			case (wr_tgt)
				soc_pkg::TGT_RAM: bresp <= soc_pkg::RESP_OKAY;
				soc_pkg::TGT_COUNTER, soc_pkg::TGT_PAD: bresp <= soc_pkg::RESP_SLVERR;
				default: bresp <= soc_pkg::RESP_DECERR;
			endcase
		end

		if (ar_fire) begin
			rd_tgt <= decode_addr(araddr);
			ram_rd_index <= araddr[soc_pkg::RAM_ADDR_BITS-1:2];
		end

		// Held until the master takes it, nothing new arrives while busy
		if (rd_capture) begin
			rresp <= (rd_tgt == soc_pkg::TGT_NONE) ? soc_pkg::RESP_DECERR : soc_pkg::RESP_OKAY;
			case (rd_tgt)
				soc_pkg::TGT_RAM: rdata <= ram_rdata;
				soc_pkg::TGT_COUNTER: rdata <= count_value;
				soc_pkg::TGT_PAD: rdata <= pad_value;
				default: rdata <= '0;
			endcase
		end
	end

endmodule

/* hw/boot_ram.sv */
// Boot memory with byte-strobed writes and registered reads
`timescale 1ns/1ps

module boot_ram (
	input logic clk_50mhz,
	input logic wr_en,
	input soc_pkg::ram_index_t wr_index,
	input soc_pkg::data_t wdata,
	input soc_pkg::strb_t wstrb,
	input logic rd_en,
	input soc_pkg::ram_index_t rd_index,
	output soc_pkg::data_t rdata
);

	soc_pkg::data_t mem [soc_pkg::RAM_WORDS];

	// One enable per byte lane
	always_ff @(posedge clk_50mhz) begin
		if (wr_en) begin
			for (int lane = 0; lane < $bits(soc_pkg::strb_t); lane++) begin
				if (wstrb[lane])
					mem[wr_index][lane*8 +: 8] <= wdata[lane*8 +: 8];
			end
		end
	end

	// Output holds its last word between reads
	always_ff @(posedge clk_50mhz) begin
		if (rd_en)
			rdata <= mem[rd_index];
	end

endmodule

/* hw/system_counter.sv */
// Free-running cycle counter with a snapshot read register
`timescale 1ns/1ps

module system_counter (
	input logic clk_50mhz,
	input logic resetn,
	input logic rd_en,
	output soc_pkg::data_t count_value
);

	soc_pkg::data_t cycle_count;

	// Wraps on overflow
	always_ff @(posedge clk_50mhz) begin
		if (!resetn)
			cycle_count <= '0;
		else
			cycle_count <= cycle_count + 1'b1;
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_en)
			count_value <= cycle_count;
	end

endmodule

/* hw/pad_reader.sv */
// Serial game-pad scanner holding the last complete button state of two pads
`timescale 1ns/1ps

module pad_reader (
	input logic clk_50mhz,
	input logic resetn,
	input logic rd_en,
	input logic pad0_data,
	input logic pad1_data,
	output logic pad0_latch,
	output logic pad0_clk,
	output logic pad1_latch,
	output logic pad1_clk,
	output soc_pkg::data_t pad_value
);

	logic [$clog2(soc_pkg::PAD_TICK_CYCLES)-1:0] tick_cnt;
	logic tick;
	logic [$clog2(soc_pkg::PAD_BITS+1)-1:0] bit_cnt;
	soc_pkg::pad_state_t state;
	logic latch_q;
	logic clk_q;
	logic [1:0] pad0_sync;
	logic [1:0] pad1_sync;
	soc_pkg::buttons_t shift0;
	soc_pkg::buttons_t shift1;
	soc_pkg::buttons_t held0;
	soc_pkg::buttons_t held1;

	// Both pads run on the same latch and clock
	assign pad0_latch = latch_q;
	assign pad1_latch = latch_q;
	assign pad0_clk = clk_q;
	assign pad1_clk = clk_q;

	// One tick per pad-clock half period
	assign tick = (tick_cnt == soc_pkg::PAD_TICK_CYCLES - 1);

	always_ff @(posedge clk_50mhz) begin
		pad0_sync <= {pad0_sync[0], pad0_data};
		pad1_sync <= {pad1_sync[0], pad1_data};
	end

	always_ff @(posedge clk_50mhz) begin
		if (!resetn) begin
			tick_cnt <= '0;
			bit_cnt <= '0;
			state <= soc_pkg::PAD_IDLE;
			latch_q <= 1'b0;
			clk_q <= 1'b0;
			held0 <= '0;
			held1 <= '0;
		end else begin
			tick_cnt <= tick ? '0 : tick_cnt + 1'b1;
			if (tick) begin
				case (state)
					soc_pkg::PAD_IDLE: begin
						latch_q <= 1'b1;
						state <= soc_pkg::PAD_LATCH;
					end
					soc_pkg::PAD_LATCH: begin
						latch_q <= 1'b0;
						clk_q <= 1'b1;
						bit_cnt <= 1'b1;
						state <= soc_pkg::PAD_SHIFT;
					end
					default: begin
						if (!clk_q) begin
							clk_q <= 1'b1;
							bit_cnt <= bit_cnt + 1'b1;
						end else if (bit_cnt == soc_pkg::PAD_BITS) begin
							// Frame done, data lines are active low
							clk_q <= 1'b0;
							latch_q <= 1'b1;
							held0 <= ~shift0;
							held1 <= ~shift1;
							state <= soc_pkg::PAD_LATCH;
						end else begin
							clk_q <= 1'b0;
						end
					end
				endcase
			end
		end
	end

	// Sample on every rising pad clock, first bit ends up in bit 0
	always_ff @(posedge clk_50mhz) begin
		if (tick && !clk_q && state != soc_pkg::PAD_IDLE) begin
			shift0 <= {pad0_sync[1], shift0[7:1]};
			shift1 <= {pad1_sync[1], shift1[7:1]};
		end
	end

	always_ff @(posedge clk_50mhz) begin
		if (rd_en)
			pad_value <= {16'h0000, held1, held0};
	end

endmodule

/* hw/soc_bus_top.sv */
// Top level joining the AXI-Lite decoder to boot memory, counter and pad reader
`timescale 1ns/1ps

module soc_bus_top (
	input logic clk_50mhz,
	input logic resetn,

	input soc_pkg::addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input soc_pkg::data_t wdata,
	input soc_pkg::strb_t wstrb,
	input logic wvalid,
	output logic wready,
	output soc_pkg::resp_t bresp,
	output logic bvalid,
	input logic bready,

	input soc_pkg::addr_t araddr,
	input logic arvalid,
	output logic arready,
	output soc_pkg::data_t rdata,
	output soc_pkg::resp_t rresp,
	output logic rvalid,
	input logic rready,

	output logic pad0_latch,
	output logic pad0_clk,
	output logic pad1_latch,
	output logic pad1_clk,
	input logic pad0_data,
	input logic pad1_data
);

	logic ram_wr_en;
	soc_pkg::ram_index_t ram_wr_index;
	soc_pkg::data_t ram_wdata;
	soc_pkg::strb_t ram_wstrb;
	logic ram_rd_en;
	soc_pkg::ram_index_t ram_rd_index;
	soc_pkg::data_t ram_rdata;
	logic counter_rd_en;
	soc_pkg::data_t count_value;
	logic pad_rd_en;
	soc_pkg::data_t pad_value;

	axil_decoder decoder (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.ram_wr_en(ram_wr_en),
		.ram_wr_index(ram_wr_index),
		.ram_wdata(ram_wdata),
		.ram_wstrb(ram_wstrb),
		.ram_rd_en(ram_rd_en),
		.ram_rd_index(ram_rd_index),
		.ram_rdata(ram_rdata),
		.counter_rd_en(counter_rd_en),
		.pad_rd_en(pad_rd_en),
		.count_value(count_value),
		.pad_value(pad_value)
	);

	boot_ram boot_memory (
		.clk_50mhz(clk_50mhz),
		.wr_en(ram_wr_en),
		.wr_index(ram_wr_index),
		.wdata(ram_wdata),
		.wstrb(ram_wstrb),
		.rd_en(ram_rd_en),
		.rd_index(ram_rd_index),
		.rdata(ram_rdata)
	);

	system_counter sys_counter (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.rd_en(counter_rd_en),
		.count_value(count_value)
	);

	pad_reader pads (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.rd_en(pad_rd_en),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data),
		.pad0_latch(pad0_latch),
		.pad0_clk(pad0_clk),
		.pad1_latch(pad1_latch),
		.pad1_clk(pad1_clk),
		.pad_value(pad_value)
	);

endmodule

/* test/pad_model.sv */
// Behavioural model of two serial game pads with settable button states
`timescale 1ns/1ps

module pad_model (
	input logic pad0_latch,
	input logic pad0_clk,
	input logic pad1_latch,
	input logic pad1_clk,
	input soc_pkg::buttons_t buttons0,
	input soc_pkg::buttons_t buttons1,
	output logic pad0_data,
	output logic pad1_data
);

	// Current bit, parked past the last button until the first latch
	int unsigned pos0 = $bits(soc_pkg::buttons_t);
	int unsigned pos1 = $bits(soc_pkg::buttons_t);

	always @(posedge pad0_latch or posedge pad0_clk) begin
		if (pad0_latch)
			pos0 <= 0;
		else
			pos0 <= pos0 + 1;
	end

	always @(posedge pad1_latch or posedge pad1_clk) begin
		if (pad1_latch)
			pos1 <= 0;
		else
			pos1 <= pos1 + 1;
	end

	// Active low, idle high once all buttons are out
	assign pad0_data = (pos0 < $bits(soc_pkg::buttons_t)) ? ~buttons0[pos0] : 1'b1;
	assign pad1_data = (pos1 < $bits(soc_pkg::buttons_t)) ? ~buttons1[pos1] : 1'b1;

endmodule

/* test/tb_soc_bus.sv */
// Testbench with clock, reset, AXI-Lite master tasks, memory scoreboard and checks
`timescale 1ns/1ps

module tb_soc_bus;

	localparam int FRAME_CYCLES = soc_pkg::PAD_FRAME_TICKS * soc_pkg::PAD_TICK_CYCLES;
	localparam int PAD_ROUNDS = 3;
	// Two frames per pad round, the rest covers the bus tests
	localparam int BUS_CYCLES = 15424;
	localparam int TIMEOUT_CYCLES = PAD_ROUNDS * 2 * FRAME_CYCLES + BUS_CYCLES;
	localparam int DRIVE_DELAY = 2;
	localparam int RAM_TESTS = 8;
	localparam int STRB_TESTS = 4;
	localparam soc_pkg::addr_t UNMAPPED_ADDR = 32'h0300_0000;

	logic clk_50mhz;
	logic resetn;
	soc_pkg::addr_t awaddr;
	logic awvalid;
	logic awready;
	soc_pkg::data_t wdata;
	soc_pkg::strb_t wstrb;
	logic wvalid;
	logic wready;
	soc_pkg::resp_t bresp;
	logic bvalid;
	logic bready;
	soc_pkg::addr_t araddr;
	logic arvalid;
	logic arready;
	soc_pkg::data_t rdata;
	soc_pkg::resp_t rresp;
	logic rvalid;
	logic rready;
	logic pad0_latch;
	logic pad0_clk;
	logic pad1_latch;
	logic pad1_clk;
	logic pad0_data;
	logic pad1_data;
	soc_pkg::buttons_t buttons0;
	soc_pkg::buttons_t buttons1;

	integer seed;
	int cycle = 0;
	int error_count = 0;
	int index;
	int used_idx[$];
	soc_pkg::data_t ram_model [int];
	soc_pkg::data_t data;
	soc_pkg::strb_t strb;
	soc_pkg::resp_t read_resp;
	soc_pkg::data_t first_count;
	soc_pkg::data_t second_count;

	soc_bus_top DUT (
		.clk_50mhz(clk_50mhz),
		.resetn(resetn),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.pad0_latch(pad0_latch),
		.pad0_clk(pad0_clk),
		.pad1_latch(pad1_latch),
		.pad1_clk(pad1_clk),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data)
	);

	pad_model pads (
		.pad0_latch(pad0_latch),
		.pad0_clk(pad0_clk),
		.pad1_latch(pad1_latch),
		.pad1_clk(pad1_clk),
		.buttons0(buttons0),
		.buttons1(buttons1),
		.pad0_data(pad0_data),
		.pad1_data(pad1_data)
	);

	initial begin
		clk_50mhz = 1'b0;
		forever #10 clk_50mhz = ~clk_50mhz;
	end

	task automatic abort_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	always @(posedge clk_50mhz) begin
		cycle <= cycle + 1;
		if (cycle >= TIMEOUT_CYCLES)
			abort_run($sformatf("Run did not finish within %0d cycles", TIMEOUT_CYCLES));
	end

	task automatic check_equal(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected)
		else abort_run($sformatf("[FAIL] %s: expected 0x%08h, actual 0x%08h",
			name, expected, actual));
	endtask

	// Byte lanes with a strobe take the new data
	function automatic soc_pkg::data_t merge_bytes(input soc_pkg::data_t old_word,
		input soc_pkg::data_t new_word, input soc_pkg::strb_t lanes);
		soc_pkg::data_t merged;
		merged = old_word;
		for (int b = 0; b < 4; b++) begin
			if (lanes[b])
				merged[b*8 +: 8] = new_word[b*8 +: 8];
		end
		return merged;
	endfunction

	// Called and returns a short delay after a rising edge
	task automatic write_word(input string name, input soc_pkg::addr_t addr,
		input soc_pkg::data_t value, input soc_pkg::strb_t lanes,
		input soc_pkg::resp_t exp_resp);
		int hs_cycle;
		int hold;
		soc_pkg::resp_t first_resp;
		awaddr = addr;
		awvalid = 1'b1;
		wdata = value;
		wstrb = lanes;
		wvalid = 1'b1;
		@(negedge clk_50mhz);
		while (!(awready && wready)) begin
			@(negedge clk_50mhz);
		end
		hs_cycle = cycle + 1;
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk_50mhz);
		while (!bvalid) begin
			@(negedge clk_50mhz);
		end
		check_equal({name, " write latency"}, 1, cycle - hs_cycle);
		first_resp = bresp;
		hold = $unsigned($random(seed)) % 4;
		repeat (hold) begin
			@(negedge clk_50mhz);
			check_equal({name, " bvalid held"}, 1, bvalid);
			check_equal({name, " bresp held"}, first_resp, bresp);
		end
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
		bready = 1'b1;
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
		bready = 1'b0;
		@(negedge clk_50mhz);
		check_equal({name, " bvalid drained"}, 0, bvalid);
		check_equal({name, " bresp"}, exp_resp, first_resp);
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
	endtask

	task automatic read_word(input string name, input soc_pkg::addr_t addr,
		output soc_pkg::data_t value, output soc_pkg::resp_t resp);
		int hs_cycle;
		int hold;
		araddr = addr;
		arvalid = 1'b1;
		@(negedge clk_50mhz);
		while (!arready) begin
			@(negedge clk_50mhz);
		end
		hs_cycle = cycle + 1;
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
		arvalid = 1'b0;
		@(negedge clk_50mhz);
		while (!rvalid) begin
			@(negedge clk_50mhz);
		end
		check_equal({name, " read latency"}, 2, cycle - hs_cycle);
		value = rdata;
		resp = rresp;
		hold = $unsigned($random(seed)) % 4;
		repeat (hold) begin
			@(negedge clk_50mhz);
			check_equal({name, " rvalid held"}, 1, rvalid);
			check_equal({name, " rdata held"}, value, rdata);
			check_equal({name, " rresp held"}, resp, rresp);
		end
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
		rready = 1'b1;
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
		rready = 1'b0;
		@(negedge clk_50mhz);
		check_equal({name, " rvalid drained"}, 0, rvalid);
		@(posedge clk_50mhz);
		#DRIVE_DELAY;
	endtask

	task automatic read_expect(input string name, input soc_pkg::addr_t addr,
		input soc_pkg::data_t exp_data, input soc_pkg::resp_t exp_resp);
		soc_pkg::data_t value;
		soc_pkg::resp_t resp;
		read_word(name, addr, value, resp);
		check_equal({name, " rresp"}, exp_resp, resp);
		check_equal({name, " rdata"}, exp_data, value);
	endtask

	initial begin
		seed = 36648;
		resetn = 1'b0;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		buttons0 = '0;
		buttons1 = '0;
		repeat (5) @(posedge clk_50mhz);
		#DRIVE_DELAY;
		resetn = 1'b1;

		@(negedge clk_50mhz);
		check_equal("reset bvalid", 0, bvalid);
		check_equal("reset rvalid", 0, rvalid);
		check_equal("reset arready", 1, arready);
		check_equal("reset pad latch", 0, pad0_latch);
		check_equal("reset pad clock", 0, pad0_clk);
		check_equal("reset pad1 latch", 0, pad1_latch);
		check_equal("reset pad1 clock", 0, pad1_clk);
		@(posedge clk_50mhz);
		#DRIVE_DELAY;

		// Full-word writes, then read back against the scoreboard
		for (int i = 0; i < RAM_TESTS; i++) begin
			index = $unsigned($random(seed)) % soc_pkg::RAM_WORDS;
			data = $random(seed);
			write_word("ram write", soc_pkg::RAM_BASE + index * 4, data, 4'hf,
				soc_pkg::RESP_OKAY);
			ram_model[index] = data;
			used_idx.push_back(index);
		end
		foreach (used_idx[i])
			read_expect("ram read", soc_pkg::RAM_BASE + used_idx[i] * 4,
				ram_model[used_idx[i]], soc_pkg::RESP_OKAY);

		for (int i = 0; i < STRB_TESTS; i++) begin
			index = used_idx[i];
			data = $random(seed);
			strb = 1 + $unsigned($random(seed)) % 14;
			write_word("strobe write", soc_pkg::RAM_BASE + index * 4, data, strb,
				soc_pkg::RESP_OKAY);
			ram_model[index] = merge_bytes(ram_model[index], data, strb);
			read_expect("strobe read", soc_pkg::RAM_BASE + index * 4, ram_model[index],
				soc_pkg::RESP_OKAY);
		end

		read_expect("unmapped read", UNMAPPED_ADDR, '0, soc_pkg::RESP_DECERR);
		read_expect("past ram read", soc_pkg::RAM_BASE + 32'h1000, '0, soc_pkg::RESP_DECERR);
		write_word("unmapped write", UNMAPPED_ADDR, 32'h1234_5678, 4'hf, soc_pkg::RESP_DECERR);
		write_word("counter write", soc_pkg::COUNTER_BASE, 32'hdead_beef, 4'hf,
			soc_pkg::RESP_SLVERR);
		write_word("pad write", soc_pkg::PAD_BASE, 32'hdead_beef, 4'hf, soc_pkg::RESP_SLVERR);
		read_expect("pad after write", soc_pkg::PAD_BASE, {16'h0000, buttons1, buttons0},
			soc_pkg::RESP_OKAY);

		read_word("counter after write", soc_pkg::COUNTER_BASE, first_count, read_resp);
		check_equal("counter after write rresp", soc_pkg::RESP_OKAY, read_resp);
		read_word("counter second", soc_pkg::COUNTER_BASE, second_count, read_resp);
		check_equal("counter second rresp", soc_pkg::RESP_OKAY, read_resp);
		assert (second_count > first_count)
		else abort_run($sformatf("[FAIL] counter advance: expected above 0x%08h, actual 0x%08h",
			first_count, second_count));

		// Two frames are enough for one full scan with the new buttons
		for (int round = 0; round < PAD_ROUNDS; round++) begin
			buttons0 = soc_pkg::buttons_t'($random(seed));
			buttons1 = soc_pkg::buttons_t'($random(seed));
			repeat (2 * FRAME_CYCLES) @(posedge clk_50mhz);
			#DRIVE_DELAY;
			read_expect("pad buttons", soc_pkg::PAD_BASE, {16'h0000, buttons1, buttons0},
				soc_pkg::RESP_OKAY);
		end

		if (error_count == 0) begin
			$display("No errors");
			$finish;
		end else begin
			$display("Errors found");
			$fatal(1);
		end
	end

endmodule

/* filelist.f */
hw/soc_pkg.sv
hw/axil_decoder.sv
hw/boot_ram.sv
hw/system_counter.sv
hw/pad_reader.sv
hw/soc_bus_top.sv
test/pad_model.sv
test/tb_soc_bus.sv
